//--- logic/eth_rx_pkg.sv
package eth_rx_pkg;

   // Station address, first byte on the wire in the top bits
   localparam logic [47:0] station_mac = 48'h02_00_5E_10_20_30;

   // Number of address bytes checked by the filter
   localparam int mac_bytes = 6;

   // Receive buffer geometry
   localparam int buf_addr_w = 11;
   localparam int buf_word_w = buf_addr_w - 2;
   localparam int buf_words = 1 << buf_word_w;

   // Wishbone side
   localparam int wb_addr_w = 12;
   localparam int wb_data_w = 32;

   // Register map, byte offsets
   localparam logic [wb_addr_w-1:0] reg_status = 12'h000;
   localparam logic [wb_addr_w-1:0] reg_ack = 12'h004;
   localparam logic [wb_addr_w-1:0] reg_crc = 12'h008;
   localparam logic [wb_addr_w-1:0] buf_base = 12'h800;

   // Status word layout
   localparam int st_ready = 0;
   localparam int st_crc_good = 1;
   localparam int st_dv_seen = 2;
   localparam int st_len_lsb = 16;
   localparam int st_len_msb = 26;

   // CRC-32, reflected form of 32'h04C11DB7
   localparam int crc_w = 32;
   localparam logic [crc_w-1:0] crc_init = 32'hFFFF_FFFF;
   localparam logic [crc_w-1:0] crc_poly = 32'hEDB8_8320;
   localparam logic [crc_w-1:0] crc_residue = 32'hC704_DD7B;

   // MII framing nibbles
   localparam logic [3:0] sfd_nibble = 4'hD;
   localparam logic [3:0] pre_nibble = 4'h5;

endpackage

//--- logic/eth_crc32.sv
`timescale 1ns/1ps

module eth_crc32 (
   input  logic                          RX_CLK,
   input  logic                          ETH_PHY_RESETN,
   input  logic                          clear,
   input  logic                          en,
   input  logic [3:0]                    nibble,
   output logic [eth_rx_pkg::crc_w-1:0] crc_value
);

   logic [eth_rx_pkg::crc_w-1:0] crc_q;
   logic [eth_rx_pkg::crc_w-1:0] crc_next;

   // Four serial steps, LSB of the nibble first
   always_comb begin
      crc_next = crc_q;
      for (int i = 0; i < 4; i++) begin
         if (crc_next[0] ^ nibble[i])
            crc_next = (crc_next >> 1) ^ eth_rx_pkg::crc_poly;
         else
            crc_next = crc_next >> 1;
      end
   end

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN)
         crc_q <= '0;
      else if (clear)
         crc_q <= eth_rx_pkg::crc_init;
      else if (en)
         crc_q <= crc_next;
   end

   // Presented MSB first, so a good frame leaves crc_residue
   always_comb begin
      for (int i = 0; i < eth_rx_pkg::crc_w; i++)
         crc_value[i] = crc_q[eth_rx_pkg::crc_w-1-i];
   end

endmodule

//--- logic/eth_mii_rx.sv
`timescale 1ns/1ps

module eth_mii_rx (
   input  logic                               RX_CLK,
   input  logic                               ETH_PHY_RESETN,
   input  logic [3:0]                         RX_DATA,
   input  logic                               RX_DV,
   input  logic [eth_rx_pkg::crc_w-1:0]      crc_value,
   input  logic                               ack_pulse,
   output logic                               crc_clear,
   output logic                               crc_en,
   output logic                               wr,
   output logic [eth_rx_pkg::buf_addr_w-1:0] wr_addr,
   output logic [7:0]                         wr_byte,
   output logic                               frame_ready,
   output logic [eth_rx_pkg::buf_addr_w-1:0] frame_len,
   output logic                               crc_good,
   output logic                               dv_seen
);

   typedef enum logic [1:0] {
      st_idle,
      st_preamble,
      st_data,
      st_drop
   } rx_state_t;

   rx_state_t                          state;
   logic                               nib_hi;
   logic [3:0]                         lo_nib;
   logic [7:0]                         rx_byte;
   logic [7:0]                         mac_byte;
   logic [eth_rx_pkg::buf_addr_w-1:0] byte_cnt;
   logic                               full;
   logic                               uc_ok;
   logic                               bc_ok;

   assign rx_byte = {RX_DATA, lo_nib};

   assign crc_clear = (state == st_preamble) && RX_DV && (RX_DATA == eth_rx_pkg::sfd_nibble);
   assign crc_en = (state == st_data) && RX_DV;

   // Station address byte matching the current position
   always_comb begin
      case (byte_cnt[2:0])
         3'd0: mac_byte = eth_rx_pkg::station_mac[47:40];
         3'd1: mac_byte = eth_rx_pkg::station_mac[39:32];
         3'd2: mac_byte = eth_rx_pkg::station_mac[31:24];
         3'd3: mac_byte = eth_rx_pkg::station_mac[23:16];
         3'd4: mac_byte = eth_rx_pkg::station_mac[15:8];
         default: mac_byte = eth_rx_pkg::station_mac[7:0];
      endcase
   end

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         state <= st_idle;
         wr <= 1'b0;
         nib_hi <= 1'b0;
         byte_cnt <= '0;
         full <= 1'b0;
         uc_ok <= 1'b0;
         bc_ok <= 1'b0;
         frame_ready <= 1'b0;
         frame_len <= '0;
         crc_good <= 1'b0;
         dv_seen <= 1'b0;
      end else begin
         wr <= 1'b0;
         if (RX_DV)
            dv_seen <= 1'b1;
         if (ack_pulse)
            frame_ready <= 1'b0;
         case (state)
            st_idle: begin
               // A held frame blocks everything until the host acknowledges
               if (RX_DV) begin
                  if (!frame_ready && RX_DATA == eth_rx_pkg::pre_nibble)
                     state <= st_preamble;
                  else
                     state <= st_drop;
               end
            end
            st_preamble: begin
               if (!RX_DV) begin
                  state <= st_idle;
               end else if (crc_clear) begin
                  state <= st_data;
                  nib_hi <= 1'b0;
                  byte_cnt <= '0;
                  full <= 1'b0;
                  uc_ok <= 1'b1;
                  bc_ok <= 1'b1;
               end else if (RX_DATA != eth_rx_pkg::pre_nibble) begin
                  state <= st_drop;
               end
            end
            st_data: begin
               if (!RX_DV) begin
                  state <= st_idle;
                  frame_ready <= uc_ok | bc_ok;
                  frame_len <= byte_cnt;
                  crc_good <= (crc_value == eth_rx_pkg::crc_residue);
               end else begin
                  nib_hi <= ~nib_hi;
                  if (nib_hi && !full) begin
                     wr <= 1'b1;
                     // Last buffer slot, count saturates here
                     if (&byte_cnt)
                        full <= 1'b1;
                     else
                        byte_cnt <= byte_cnt + 1'b1;
                     if (byte_cnt < eth_rx_pkg::mac_bytes) begin
                        if (rx_byte != mac_byte)
                           uc_ok <= 1'b0;
                        if (rx_byte != 8'hFF)
                           bc_ok <= 1'b0;
                     end
                  end
               end
            end
            st_drop: begin
               if (!RX_DV)
                  state <= st_idle;
            end
            default: state <= st_idle;
         endcase
      end
   end

   // Byte assembly, low nibble first
   always_ff @(posedge RX_CLK) begin
      if (crc_en) begin
         if (!nib_hi) begin
            lo_nib <= RX_DATA;
         end else begin
            wr_byte <= rx_byte;
            wr_addr <= byte_cnt;
         end
      end
   end

endmodule

//--- logic/eth_rx_buffer.sv
`timescale 1ns/1ps

module eth_rx_buffer (
   input  logic                               RX_CLK,
   input  logic                               wr,
   input  logic [eth_rx_pkg::buf_addr_w-1:0] wr_addr,
   input  logic [7:0]                         wr_byte,
   input  logic                               rd_en,
   input  logic [eth_rx_pkg::buf_word_w-1:0] rd_word_addr,
   output logic [31:0]                        rd_data
);

   logic [31:0] mem [eth_rx_pkg::buf_words];
   logic [3:0]  lane_we;
   logic [31:0] wr_word;

   // Byte n lands in lane n mod 4
   assign lane_we = {3'b000, wr} << wr_addr[1:0];
   assign wr_word = {4{wr_byte}};

   always_ff @(posedge RX_CLK) begin
      for (int i = 0; i < 4; i++) begin
         if (lane_we[i])
            mem[wr_addr[eth_rx_pkg::buf_addr_w-1:2]][8*i +: 8] <= wr_word[8*i +: 8];
      end
   end

   // Host side read, one word per access
   always_ff @(posedge RX_CLK) begin
      if (rd_en)
         rd_data <= mem[rd_word_addr];
   end

endmodule

//--- logic/eth_rx_regs.sv
`timescale 1ns/1ps

module eth_rx_regs (
   input  logic                               RX_CLK,
   input  logic                               ETH_PHY_RESETN,
   input  logic                               wb_cyc,
   input  logic                               wb_stb,
   input  logic                               wb_we,
   input  logic [eth_rx_pkg::wb_addr_w-1:0]  wb_adr,
   input  logic [eth_rx_pkg::wb_data_w-1:0]  wb_dat_w,
   input  logic [3:0]                         wb_sel,
   output logic [eth_rx_pkg::wb_data_w-1:0]  wb_dat_r,
   output logic                               wb_ack,
   input  logic                               frame_ready,
   input  logic [eth_rx_pkg::buf_addr_w-1:0] frame_len,
   input  logic                               crc_good,
   input  logic                               dv_seen,
   input  logic [eth_rx_pkg::crc_w-1:0]      crc_value,
   output logic                               rd_en,
   output logic [eth_rx_pkg::buf_word_w-1:0] rd_word_addr,
   input  logic [31:0]                        buf_data,
   output logic                               ack_pulse
);

   logic                              start;
   logic                              is_buf;
   logic [eth_rx_pkg::wb_addr_w-3:0] word_sel;
   logic [eth_rx_pkg::wb_data_w-1:0] status_word;
   logic [eth_rx_pkg::wb_data_w-1:0] reg_mux;
   logic [eth_rx_pkg::wb_data_w-1:0] reg_rdata;

   // New request, not yet acknowledged
   assign start = wb_cyc & wb_stb & ~wb_ack;
   assign is_buf = (wb_adr & eth_rx_pkg::buf_base) != '0;
   assign word_sel = wb_adr[eth_rx_pkg::wb_addr_w-1:2];

   // Memory read runs in the same cycle as the acknowledge
   assign rd_en = start & ~wb_we & is_buf;
   assign rd_word_addr = wb_adr[eth_rx_pkg::buf_addr_w-1:2];

   always_comb begin
      status_word = '0;
      status_word[eth_rx_pkg::st_ready] = frame_ready;
      status_word[eth_rx_pkg::st_crc_good] = crc_good;
      status_word[eth_rx_pkg::st_dv_seen] = dv_seen;
      status_word[eth_rx_pkg::st_len_msb:eth_rx_pkg::st_len_lsb] = frame_len;
   end

   // reg_ack and unmapped offsets read as zero
   always_comb begin
      case (word_sel)
         eth_rx_pkg::reg_status[eth_rx_pkg::wb_addr_w-1:2]: reg_mux = status_word;
         eth_rx_pkg::reg_crc[eth_rx_pkg::wb_addr_w-1:2]: reg_mux = crc_value;
         default: reg_mux = '0;
      endcase
   end

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         wb_ack <= 1'b0;
         ack_pulse <= 1'b0;
      end else begin
         wb_ack <= start;
         ack_pulse <= start & wb_we & ~is_buf & wb_sel[0] & wb_dat_w[0] &
                      (word_sel == eth_rx_pkg::reg_ack[eth_rx_pkg::wb_addr_w-1:2]);
      end
   end

   always_ff @(posedge RX_CLK) begin
      if (start)
         reg_rdata <= reg_mux;
   end

   // Address is still held by the host during the acknowledge
   assign wb_dat_r = is_buf ? buf_data : reg_rdata;

endmodule

//--- logic/eth_rx_top.sv
`timescale 1ns/1ps

module eth_rx_top (
   input  logic                              RX_CLK,
   input  logic                              ETH_PHY_RESETN,
   input  logic [3:0]                        RX_DATA,
   input  logic                              RX_DV,
   input  logic                              wb_cyc,
   input  logic                              wb_stb,
   input  logic                              wb_we,
   input  logic [eth_rx_pkg::wb_addr_w-1:0] wb_adr,
   input  logic [eth_rx_pkg::wb_data_w-1:0] wb_dat_w,
   input  logic [3:0]                        wb_sel,
   output logic [eth_rx_pkg::wb_data_w-1:0] wb_dat_r,
   output logic                              wb_ack
);

   logic                               crc_clear;
   logic                               crc_en;
   logic [eth_rx_pkg::crc_w-1:0]      crc_value;
   logic                               wr;
   logic [eth_rx_pkg::buf_addr_w-1:0] wr_addr;
   logic [7:0]                         wr_byte;
   logic                               frame_ready;
   logic [eth_rx_pkg::buf_addr_w-1:0] frame_len;
   logic                               crc_good;
   logic                               dv_seen;
   logic                               ack_pulse;
   logic                               rd_en;
   logic [eth_rx_pkg::buf_word_w-1:0] rd_word_addr;
   logic [31:0]                        buf_data;

   eth_mii_rx eth_mii_rx_inst (
      .RX_CLK         (RX_CLK),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .RX_DATA        (RX_DATA),
      .RX_DV          (RX_DV),
      .crc_value      (crc_value),
      .ack_pulse      (ack_pulse),
      .crc_clear      (crc_clear),
      .crc_en         (crc_en),
      .wr             (wr),
      .wr_addr        (wr_addr),
      .wr_byte        (wr_byte),
      .frame_ready    (frame_ready),
      .frame_len      (frame_len),
      .crc_good       (crc_good),
      .dv_seen        (dv_seen)
   );

   // CRC sees the raw MII nibble
   eth_crc32 eth_crc32_inst (
      .RX_CLK         (RX_CLK),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .clear          (crc_clear),
      .en             (crc_en),
      .nibble         (RX_DATA),
      .crc_value      (crc_value)
   );

   eth_rx_buffer eth_rx_buffer_inst (
      .RX_CLK       (RX_CLK),
      .wr           (wr),
      .wr_addr      (wr_addr),
      .wr_byte      (wr_byte),
      .rd_en        (rd_en),
      .rd_word_addr (rd_word_addr),
      .rd_data      (buf_data)
   );

   eth_rx_regs eth_rx_regs_inst (
      .RX_CLK         (RX_CLK),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .wb_cyc         (wb_cyc),
      .wb_stb         (wb_stb),
      .wb_we          (wb_we),
      .wb_adr         (wb_adr),
      .wb_dat_w       (wb_dat_w),
      .wb_sel         (wb_sel),
      .wb_dat_r       (wb_dat_r),
      .wb_ack         (wb_ack),
      .frame_ready    (frame_ready),
      .frame_len      (frame_len),
      .crc_good       (crc_good),
      .dv_seen        (dv_seen),
      .crc_value      (crc_value),
      .rd_en          (rd_en),
      .rd_word_addr   (rd_word_addr),
      .buf_data       (buf_data),
      .ack_pulse      (ack_pulse)
   );

endmodule

//--- testbench/eth_rx_properties.sv
`timescale 1ns/1ps

module eth_rx_properties (
   input logic        RX_CLK,
   input logic        ETH_PHY_RESETN,
   input logic        wb_cyc,
   input logic        wb_stb,
   input logic        wb_ack,
   input logic        wr,
   input logic [10:0] wr_addr
);

   // Classic cycle acknowledge lasts one clock
   ack_single: assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      wb_ack |=> !wb_ack)
      else $error("wb_ack stayed high for two cycles");

   ack_after_request: assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
      else $error("wb_ack rose without cyc and stb");

   // Buffer writes advance one byte at a time and never run past byte 2047
   wr_in_order: assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      wr && $past(wr, 2) |-> ({1'b0, wr_addr} == {1'b0, $past(wr_addr, 2)} + 12'd1))
      else $error("buffer write address skipped or wrapped past the end");

endmodule

// wr and wr_addr live in the top level, next to the Wishbone ports
bind eth_rx_top eth_rx_properties eth_rx_properties_inst (
   .RX_CLK         (RX_CLK),
   .ETH_PHY_RESETN (ETH_PHY_RESETN),
   .wb_cyc         (wb_cyc),
   .wb_stb         (wb_stb),
   .wb_ack         (wb_ack),
   .wr             (wr),
   .wr_addr        (wr_addr)
);

//--- testbench/eth_rx_checker.sv
`timescale 1ns/1ps

module eth_rx_checker (
   input logic        RX_CLK,
   input logic        ETH_PHY_RESETN,
   input logic        wb_ack,
   input logic        wb_we,
   input logic [11:0] wb_adr,
   input logic [31:0] wb_dat_r
);

   logic [31:0] exp_q [$];
   logic [31:0] exp_word;
   int          test_num = 0;
   int          test_errs = 0;
   int          passed = 0;
   int          failed = 0;

   function automatic string reg_name(input logic [11:0] adr);
      if (adr[11])
         return $sformatf("buf_word[%0d]", adr[10:2]);
      else if (adr == 12'h008)
         return "reg_crc";
      else
         return "reg_status";
   endfunction

   task automatic push_expect(input logic [31:0] data);
      exp_q.push_back(data);
   endtask

   // Host keeps adr and we during the acknowledge cycle
   always @(posedge RX_CLK) begin
      if (ETH_PHY_RESETN && wb_ack && !wb_we) begin
         if (exp_q.size() == 0) begin
            $display("Read of 0x%03h acknowledged with no expected value", wb_adr);
            test_errs++;
         end else begin
            exp_word = exp_q.pop_front();
            if (wb_dat_r !== exp_word) begin
               $display("ERR %s: got 0x%08h expected 0x%08h", reg_name(wb_adr),
                        wb_dat_r, exp_word);
               test_errs++;
            end
         end
      end
   end

   task automatic finish_test(input string name);
      test_num++;
      if (exp_q.size() != 0) begin
         $display("Test %0d left %0d reads without an acknowledge", test_num, exp_q.size());
         test_errs++;
         exp_q.delete();
      end
      if (test_errs == 0) begin
         passed++;
         $display("test %0d %s: passed", test_num, name);
      end else begin
         failed++;
         $display("test %0d %s: failed with %0d errors", test_num, name, test_errs);
      end
      test_errs = 0;
   endtask

   task automatic report_totals(output int fails);
      $display("tests passed: %0d, tests failed: %0d", passed, failed);
      fails = failed;
   endtask

endmodule

//--- testbench/eth_rx_tb.sv
`timescale 1ns/1ps

module eth_rx_tb;

   logic        RX_CLK;
   logic        ETH_PHY_RESETN;
   logic [3:0]  RX_DATA;
   logic        RX_DV;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   logic [11:0] wb_adr;
   logic [31:0] wb_dat_w;
   logic [3:0]  wb_sel;
   logic [31:0] wb_dat_r;
   logic        wb_ack;

   logic [7:0]  stim_mem [0:255];
   logic [7:0]  frame_q [$];
   logic [7:0]  held_q [$];
   int          cycles = 0;
   int          limit = 0;
   int          fails;

   eth_rx_top eth_rx_top_inst (
      .RX_CLK         (RX_CLK),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .RX_DATA        (RX_DATA),
      .RX_DV          (RX_DV),
      .wb_cyc         (wb_cyc),
      .wb_stb         (wb_stb),
      .wb_we          (wb_we),
      .wb_adr         (wb_adr),
      .wb_dat_w       (wb_dat_w),
      .wb_sel         (wb_sel),
      .wb_dat_r       (wb_dat_r),
      .wb_ack         (wb_ack)
   );

   eth_rx_checker eth_rx_checker_inst (
      .RX_CLK         (RX_CLK),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .wb_ack         (wb_ack),
      .wb_we          (wb_we),
      .wb_adr         (wb_adr),
      .wb_dat_r       (wb_dat_r)
   );

   initial begin
      RX_CLK = 1'b0;
      forever #5 RX_CLK = ~RX_CLK;
   end

   always @(posedge RX_CLK) begin
      cycles = cycles + 1;
      if (limit > 0 && cycles >= limit) begin
         $display("Timeout: run still busy after %0d clock cycles", cycles);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   // Standard Ethernet FCS over the first n bytes, sent low byte first
   function automatic logic [31:0] fcs_of(input int n);
      logic [31:0] crc;
      crc = 32'hFFFF_FFFF;
      for (int i = 0; i < n; i++) begin
         crc = crc ^ {24'h0, frame_q[i]};
         for (int b = 0; b < 8; b++)
            crc = crc[0] ? ((crc >> 1) ^ 32'hEDB8_8320) : (crc >> 1);
      end
      return ~crc;
   endfunction

   task automatic bus_read(input logic [11:0] adr, input logic [31:0] exp, input int waits);
      @(negedge RX_CLK);
      eth_rx_checker_inst.push_expect(exp);
      wb_adr = adr;
      wb_we = 1'b0;
      wb_cyc = 1'b1;
      // Cycle opened, strobe held back for the wait states
      repeat (waits) @(negedge RX_CLK);
      wb_stb = 1'b1;
      do @(negedge RX_CLK); while (!wb_ack);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
   endtask

   // Same location twice, without and with wait states
   task automatic check_read(input logic [11:0] adr, input logic [31:0] exp);
      bus_read(adr, exp, 0);
      bus_read(adr, exp, int'($urandom_range(1, 4)));
   endtask

   task automatic release_frame();
      @(negedge RX_CLK);
      wb_adr = 12'h004;
      wb_we = 1'b1;
      wb_dat_w = 32'h1;
      wb_sel = 4'hF;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      do @(negedge RX_CLK); while (!wb_ack);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
   endtask

   task automatic send_frame(input int pre);
      @(negedge RX_CLK);
      RX_DV = 1'b1;
      repeat (pre) begin
         RX_DATA = 4'h5;
         @(negedge RX_CLK);
      end
      RX_DATA = 4'hD;
      @(negedge RX_CLK);
      foreach (frame_q[i]) begin
         RX_DATA = frame_q[i][3:0];
         @(negedge RX_CLK);
         RX_DATA = frame_q[i][7:4];
         @(negedge RX_CLK);
      end
      RX_DV = 1'b0;
      RX_DATA = 4'h0;
      repeat ($urandom_range(12, 40)) @(negedge RX_CLK);
   endtask

   task automatic end_test(input string name);
      // Let the last compare happen on the following rising edge
      @(negedge RX_CLK);
      eth_rx_checker_inst.finish_test(name);
   endtask

   initial begin
      int          p;
      int          n;
      int          nib;
      int          frames;
      int          rec;
      logic [7:0]  flags;
      logic [10:0] len;
      logic [31:0] crc;
      logic [31:0] fcs;
      logic [31:0] status;

      RX_DATA = 4'h0;
      RX_DV = 1'b0;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      wb_adr = 12'h000;
      wb_dat_w = 32'h0;
      wb_sel = 4'hF;
      ETH_PHY_RESETN = 1'b0;
      void'($urandom(32'h1b13_a83b));
      $readmemh("testbench/eth_rx_stim.txt", stim_mem);

      // Frame nibbles, worst gaps and reads, doubled
      p = 0;
      nib = 0;
      frames = 0;
      while (stim_mem[p] != 8'h00) begin
         n = int'(stim_mem[p]);
         nib = nib + int'(stim_mem[p + 1]) + 1 + 2 * (n + 4);
         frames++;
         p = p + 8 + n;
      end
      limit = 2 * (nib + 40 * frames + 18 * 8 * (frames + 1)) + 1000;

      repeat (2) @(negedge RX_CLK);
      ETH_PHY_RESETN = 1'b1;

      check_read(12'h000, 32'h0);
      check_read(12'h008, 32'h0);
      end_test("reset values");

      p = 0;
      rec = 0;
      while (stim_mem[p] != 8'h00) begin
         n = int'(stim_mem[p]);
         flags = stim_mem[p + 2];
         len = {3'b000, stim_mem[p + 3]};
         crc = {stim_mem[p + 4], stim_mem[p + 5], stim_mem[p + 6], stim_mem[p + 7]};
         rec++;
         frame_q.delete();
         for (int i = 0; i < n; i++)
            frame_q.push_back(stim_mem[p + 8 + i]);
         if (flags[0]) begin
            fcs = fcs_of(n);
            for (int i = 0; i < 4; i++)
               frame_q.push_back(fcs[8*i +: 8]);
         end
         if (flags[1])
            frame_q[frame_q.size() - 1] = frame_q[frame_q.size() - 1] ^ 8'h80;
         send_frame(int'(stim_mem[p + 1]));
         // A discarded frame leaves the held one in the buffer
         if (!flags[4])
            held_q = frame_q;
         status = {5'd0, len, 13'd0, 1'b1, flags[3], flags[2]};
         check_read(12'h000, status);
         check_read(12'h008, crc);
         if (flags[2]) begin
            for (int w = 0; w < int'(len) / 4; w++)
               check_read(12'h800 + 12'(4 * w), {held_q[4*w+3], held_q[4*w+2],
                                                 held_q[4*w+1], held_q[4*w]});
         end
         if (flags[5]) begin
            release_frame();
            check_read(12'h000, status & 32'hFFFF_FFFE);
         end
         end_test($sformatf("frame %0d", rec));
         p = p + 8 + n;
      end

      eth_rx_checker_inst.report_totals(fails);
      if (fails == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

//--- testbench/eth_rx_stim.txt
// Per record: byte count, preamble nibbles, flags, expected length, expected reg_crc (4 bytes),
// then the frame bytes after the SFD. Flags: 01 append FCS, 02 flip bit 7 of last byte,
// 04 frame_ready, 08 crc_good, 10 frame is discarded, 20 write reg_ack after the checks.
// A byte count of 00 ends the list.

// Unicast to the station, good FCS
14 0F 2D 18 C7 04 DD 7B
02 00 5E 10 20 30 02 11 22 33 44 55 08 00 01 02 03 04 05 06

// Broadcast, good FCS
14 0B 2D 18 C7 04 DD 7B
FF FF FF FF FF FF 02 11 22 33 44 66 08 06 00 01 08 00 06 04

// Other destination, rejected by the address filter
14 0F 09 18 C7 04 DD 7B
02 00 5E 10 20 31 02 11 22 33 44 77 08 00 A1 A2 A3 A4 A5 A6

// Unicast with the last FCS byte corrupted, held without acknowledge
14 0F 07 18 C3 C5 C0 CC
02 00 5E 10 20 30 02 11 22 33 44 88 08 00 B1 B2 B3 B4 B5 B6

// Sent while the previous frame is held, so nothing changes
14 0F 35 18 C3 C5 C0 CC
02 00 5E 10 20 30 02 11 22 33 44 99 08 00 C1 C2 C3 C4 C5 C6

// Received normally after the acknowledge
14 07 2D 18 C7 04 DD 7B
02 00 5E 10 20 30 02 AA BB CC DD EE 88 B5 D1 D2 D3 D4 D5 D6

00

//--- src.f
logic/eth_rx_pkg.sv
logic/eth_crc32.sv
logic/eth_mii_rx.sv
logic/eth_rx_buffer.sv
logic/eth_rx_regs.sv
logic/eth_rx_top.sv
testbench/eth_rx_properties.sv
testbench/eth_rx_checker.sv
testbench/eth_rx_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the receive core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module eth_rx_tb -f src.f -o eth_rx_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/eth_rx_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
   exit 0
fi
exit 1
